// ==== Makefile ====
VERILATOR  ?= verilator
TOP        := tb_text_console
FILELIST   := text_console.f
OBJ_DIR    := obj_dir
SIM_FLAGS  := --binary --timing -Wno-fatal
LINT_FLAGS := --lint-only --timing -Wall

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP)

clean:
	rm -rf $(OBJ_DIR)

// ==== bench/tb_text_console.sv ====
`timescale 1ns/10ps

module tb_text_console
	import console_pkg::*;
;
	localparam int COLS = 8;
	localparam int ROWS = 4;
	localparam int BLINK_FRAMES = 2;
	localparam int H_FRONT = 4;
	localparam int H_SYNC = 4;
	localparam int H_BACK = 4;
	localparam int V_FRONT = 2;
	localparam int V_SYNC = 2;
	localparam int V_BACK = 2;
	localparam int LINE_CYCLES = COLS * 8 + H_FRONT + H_SYNC + H_BACK;
	localparam int FRAME_CYCLES = LINE_CYCLES * (ROWS * 8 + V_FRONT + V_SYNC + V_BACK);
	localparam int APB_TIMEOUT = 200;
	localparam int NSTEPS = 28;

	typedef struct packed {
		logic [7:0] code;
		logic [7:0] col;
		logic [7:0] row;
		logic frame;	// compare a whole frame after this step.
	} step_t;

	// ==================================================
	// stimulus table of codes and the cursor expected after each
	// ==================================================

	localparam step_t STEPS [NSTEPS] = '{
		'{"H", 8'd1, 8'd0, 1'b0}, '{"E", 8'd2, 8'd0, 1'b0}, '{"L", 8'd3, 8'd0, 1'b0},
		'{"L", 8'd4, 8'd0, 1'b0}, '{"O", 8'd5, 8'd0, 1'b0}, '{"a", 8'd6, 8'd0, 1'b0},
		'{"b", 8'd7, 8'd0, 1'b0}, '{"c", 8'd0, 8'd1, 1'b0}, '{"x", 8'd1, 8'd1, 1'b0},
		'{"y", 8'd2, 8'd1, 1'b1}, '{CH_CR, 8'd0, 8'd1, 1'b0}, '{"p", 8'd1, 8'd1, 1'b0},
		'{"q", 8'd2, 8'd1, 1'b0}, '{CH_BS, 8'd1, 8'd1, 1'b0}, '{CH_BS, 8'd0, 8'd1, 1'b0},
		'{CH_BS, 8'd0, 8'd1, 1'b0}, '{8'h01, 8'd0, 8'd1, 1'b0}, '{8'h7F, 8'd0, 8'd1, 1'b0},
		'{8'h1B, 8'd0, 8'd1, 1'b1}, '{"k", 8'd1, 8'd1, 1'b1}, '{CH_LF, 8'd0, 8'd2, 1'b0},
		'{CH_LF, 8'd0, 8'd3, 1'b0}, '{"e", 8'd1, 8'd3, 1'b0}, '{"n", 8'd2, 8'd3, 1'b0},
		'{"d", 8'd3, 8'd3, 1'b0}, '{CH_LF, 8'd0, 8'd3, 1'b1}, '{CH_FF, 8'd0, 8'd0, 1'b1},
		'{"A", 8'd1, 8'd0, 1'b0}
	};

	logic pixclk = 1'b0;
	logic resetcountdown;
	logic psel;
	logic penable;
	logic pwrite;
	logic [3:0] paddr;
	logic [31:0] pwdata;
	logic [31:0] prdata;
	logic pready;
	logic pslverr;
	logic hs;
	logic vs;
	logic de;
	logic pixel;
	char_t glyph_char;
	logic [2:0] glyph_row;
	logic [7:0] glyph_bits;

	logic [7:0] screen [ROWS][COLS];	// expected characters in screen order.
	int sh_col;
	int sh_row;
	int vs_count;
	logic vs_last;

	text_console #(
		.COLS(COLS), .ROWS(ROWS), .H_ACTIVE_CELLS(COLS),
		.H_FRONT(H_FRONT), .H_SYNC(H_SYNC), .H_BACK(H_BACK),
		.V_FRONT(V_FRONT), .V_SYNC(V_SYNC), .V_BACK(V_BACK),
		.BLINK_FRAMES(BLINK_FRAMES)
	) dut (
		.pixclk(pixclk), .resetcountdown(resetcountdown),
		.psel(psel), .penable(penable), .pwrite(pwrite), .paddr(paddr), .pwdata(pwdata),
		.prdata(prdata), .pready(pready), .pslverr(pslverr),
		.hs(hs), .vs(vs), .de(de), .pixel(pixel),
		.glyph_char(glyph_char), .glyph_row(glyph_row), .glyph_bits(glyph_bits)
	);

	assign glyph_bits = glyph_char ^ (8'(glyph_row) * 8'h11);	// font model.

	always #50 pixclk = ~pixclk;

	always @(negedge pixclk) begin
		if (!resetcountdown) begin
			vs_count <= 0;
			vs_last <= 1'b0;
		end else begin
			vs_last <= vs;
			if (vs && !vs_last)
				vs_count <= vs_count + 1;	// one frame index per vs rising edge.
		end
	end

	task automatic check(input logic [31:0] actual, input logic [31:0] expected,
			input string what);
		if (actual !== expected) begin
			$display("error at %0t ns: %s, got %0h, expected %0h", $time, what, actual,
				expected);
			$display("CHECKS FAILED");
			$fatal(1, "stopped at the first mismatch");
		end
	endtask

	task automatic report_timeout(input string what);
		$display("timeout at %0t ns: %s", $time, what);
		$display("CHECKS FAILED");
		$fatal(1, "stopped on a timeout");
	endtask

	// ==================================================
	// APB driver
	// ==================================================

	task automatic apb_transfer(input logic write, input logic [3:0] addr,
			input logic [31:0] data, input int gap, output logic [31:0] rdata,
			output logic err, output int stall);
		int n;
		n = 0;
		repeat (gap) @(posedge pixclk);
		@(posedge pixclk);
		psel <= 1'b1;
		penable <= 1'b0;
		pwrite <= write;
		paddr <= addr;
		pwdata <= data;
		@(posedge pixclk);
		penable <= 1'b1;
		@(negedge pixclk);
		while (!pready) begin
			if (n == APB_TIMEOUT)
				report_timeout("pready never rose in an APB access");
			n++;
			@(negedge pixclk);
		end
		rdata = prdata;
		err = pslverr;
		stall = n;
		@(posedge pixclk);
		psel <= 1'b0;
		penable <= 1'b0;
	endtask

	task automatic write_char(input logic [7:0] code, input int gap, output int stall);
		logic [31:0] unused_data;
		logic err;
		apb_transfer(1'b1, ADDR_TXDATA, {24'd0, code}, gap, unused_data, err, stall);
		check(err, 0, "pslverr on a character write");
	endtask

	task automatic read_status(output logic [31:0] status);
		logic err;
		int stall;
		apb_transfer(1'b0, ADDR_STATUS, '0, 0, status, err, stall);
		check(err, 0, "pslverr on a status read");
	endtask

	task automatic wait_idle(output logic [31:0] status);
		int n;
		n = 0;
		read_status(status);
		while (status[STATUS_BUSY_BIT]) begin
			if (n == 100)
				report_timeout("busy in the status word did not clear");
			n++;
			read_status(status);
		end
	endtask

	// ==================================================
	// shadow screen model
	// ==================================================

	task automatic clear_shadow();
		for (int r = 0; r < ROWS; r++)
			for (int c = 0; c < COLS; c++)
				screen[r][c] = CH_SPACE;
		sh_col = 0;
		sh_row = 0;
	endtask

	task automatic shadow_newline();
		if (sh_row < ROWS - 1) begin
			sh_row++;
		end else begin
			for (int r = 0; r < ROWS - 1; r++)
				for (int c = 0; c < COLS; c++)
					screen[r][c] = screen[r + 1][c];	// top row scrolls away.
			for (int c = 0; c < COLS; c++)
				screen[ROWS - 1][c] = CH_SPACE;
		end
	endtask

	task automatic shadow_apply(input logic [7:0] code);
		if (code >= CH_SPACE && code < 8'h7F) begin
			screen[sh_row][sh_col] = code;
			if (sh_col == COLS - 1) begin
				sh_col = 0;
				shadow_newline();
			end else begin
				sh_col++;
			end
		end else if (code == CH_CR) begin
			sh_col = 0;
		end else if (code == CH_LF) begin
			sh_col = 0;
			shadow_newline();
		end else if (code == CH_BS) begin
			if (sh_col > 0)
				sh_col--;
		end else if (code == CH_FF) begin
			clear_shadow();
		end
	endtask

	// ==================================================
	// frame checker
	// ==================================================

	task automatic wait_vs_rise();
		int n;
		logic last;
		n = 0;
		@(negedge pixclk);
		last = vs;
		@(negedge pixclk);
		while (!(vs && !last)) begin
			if (n == 2 * FRAME_CYCLES)
				report_timeout("no vs rising edge within two frames");
			last = vs;
			n++;
			@(negedge pixclk);
		end
	endtask

	// front porch, sync pulse and back porch follow the last active pixel of a line.
	task automatic verify_hblank();
		logic expect_hs;
		for (int j = 1; j <= H_FRONT + H_SYNC + H_BACK; j++) begin
			@(negedge pixclk);
			expect_hs = (j > H_FRONT) && (j <= H_FRONT + H_SYNC);
			check(de, 0, "de high in horizontal blanking");
			check(hs, expect_hs, "hs against the horizontal blanking");
		end
	endtask

	task automatic compare_frame(output int idx);
		int n;
		int k;
		int x;
		int y;
		logic visible;
		logic [7:0] glyph;
		logic expect_px;
		wait_vs_rise();
		@(posedge pixclk);
		idx = vs_count;
		visible = ((idx / BLINK_FRAMES) % 2) == 0;
		for (k = 0; k < COLS * ROWS * 64; k++) begin
			n = 0;
			@(negedge pixclk);
			while (!de) begin
				if (n == 8 * LINE_CYCLES)
					report_timeout("de stayed low inside a frame");
				n++;
				@(negedge pixclk);
			end
			x = k % (COLS * 8);
			y = k / (COLS * 8);
			glyph = screen[y / 8][x / 8] ^ (8'(y % 8) * 8'h11);
			expect_px = glyph[7 - x % 8];	// bit 7 is the leftmost pixel.
			if (visible && (y / 8) == sh_row && (x / 8) == sh_col)
				expect_px = ~expect_px;
			check(hs, 0, "hs high during active video");
			check(pixel, expect_px, $sformatf("pixel x=%0d y=%0d in frame %0d", x, y, idx));
			if (x == COLS * 8 - 1)
				verify_hblank();
		end
	endtask

	task automatic run_steps(input int first, input int last);
		logic [31:0] status;
		int stall;
		int idx;
		for (int i = first; i <= last; i++) begin
			write_char(STEPS[i].code, $urandom_range(0, 3), stall);
			shadow_apply(STEPS[i].code);
			wait_idle(status);
			check(status[STATUS_COL_LSB +: 8], STEPS[i].col,
				$sformatf("column after step %0d", i));
			check(status[STATUS_ROW_LSB +: 8], STEPS[i].row,
				$sformatf("row after step %0d", i));
			if (STEPS[i].frame)
				compare_frame(idx);
		end
	endtask

	initial begin
		logic [31:0] status;
		logic [31:0] data;
		logic err;
		int stall;
		int idx;
		int first_idx;
		void'($urandom(93));
		resetcountdown = 1'b0;
		psel = 1'b0;
		penable = 1'b0;
		pwrite = 1'b0;
		paddr = '0;
		pwdata = '0;
		clear_shadow();
		repeat (2) @(posedge pixclk);
		resetcountdown <= 1'b1;

		read_status(status);
		check(status[STATUS_BUSY_BIT], 1, "busy during the clear after reset");
		wait_idle(status);
		check(status, 0, "status after the clear");
		compare_frame(idx);

		run_steps(0, 25);

		// a second scroll with the next character sent straight behind it.
		write_char(CH_LF, 0, stall);
		shadow_apply(CH_LF);
		write_char("Z", 0, stall);
		shadow_apply("Z");
		check(stall > 0, 1, "pready stall while the bottom row clears");
		wait_idle(status);
		check(status[STATUS_COL_LSB +: 8], 1, "column after the scroll");
		check(status[STATUS_ROW_LSB +: 8], ROWS - 1, "row after the scroll");
		compare_frame(idx);

		run_steps(26, 27);
		apb_transfer(1'b0, 4'h8, '0, 0, data, err, stall);
		check(err, 1, "pslverr on an unmapped read");
		check(data, 0, "prdata on an unmapped read");

		compare_frame(first_idx);
		for (int f = 1; f < 4; f++) begin
			compare_frame(idx);
			check(idx, first_idx + f, "frame index of consecutive frames");
		end

		$display("ALL CHECKS PASSED");
		$finish;
	end

endmodule

// ==== hw/apb_console_regs.sv ====
`timescale 1ns/10ps

module apb_console_regs
	import console_pkg::*;
(
	input logic pixclk,
	input logic resetcountdown,
	input logic psel,
	input logic penable,
	input logic pwrite,
	input logic [3:0] paddr,
	input logic [31:0] pwdata,
	output logic [31:0] prdata,
	output logic pready,
	output logic pslverr,
	output logic tx_valid,
	output char_t tx_char,
	input logic tx_ready,
	input logic [7:0] cursor_col,
	input logic [7:0] cursor_row
);
	logic setup;
	logic access;
	logic tx_setup;
	logic [31:0] status;

	assign setup = psel && !penable;
	assign access = psel && penable;
	assign tx_setup = setup && pwrite && (paddr == ADDR_TXDATA);

	always_comb begin
		status = '0;
		status[STATUS_BUSY_BIT] = ~tx_ready;
		status[STATUS_COL_LSB +: 8] = cursor_col;
		status[STATUS_ROW_LSB +: 8] = cursor_row;
	end

	// the request is raised in the setup phase so the writer can take it in the first access cycle.
	always_ff @(posedge pixclk) begin
		if (!resetcountdown) begin
			tx_valid <= 1'b0;
		end else if (tx_setup) begin
			tx_valid <= 1'b1;
		end else if (tx_valid && tx_ready) begin
			tx_valid <= 1'b0;	// handed over, the access phase ends this cycle.
		end
	end

	always_ff @(posedge pixclk) begin
		if (tx_setup)
			tx_char <= pwdata[7:0];
	end

	// ==================================================
	// access phase response
	// ==================================================

	always_comb begin
		pready = 1'b0;
		pslverr = 1'b0;
		prdata = '0;
		if (access) begin
			case (paddr)
				ADDR_TXDATA: begin
					pready = pwrite ? (tx_valid && tx_ready) : 1'b1;	// stall until taken.
				end
				ADDR_STATUS: begin
					pready = 1'b1;
					if (!pwrite)
						prdata = status;
				end
				default: begin
					pready = 1'b1;
					pslverr = 1'b1;	// unmapped offset.
				end
			endcase
		end
	end

endmodule

// ==== hw/console_pkg.sv ====
package console_pkg;

	// ==================================================
	// character codes
	// ==================================================

	typedef logic [7:0] char_t;

	localparam char_t CH_BS = 8'h08;	// backspace, steps the cursor left.
	localparam char_t CH_LF = 8'h0A;	// line feed, also returns the carriage.
	localparam char_t CH_FF = 8'h0C;	// form feed, clears and homes.
	localparam char_t CH_CR = 8'h0D;
	localparam char_t CH_SPACE = 8'h20;	// fill code and first printable code.

	// ==================================================
	// APB register map
	// ==================================================

	localparam logic [3:0] ADDR_TXDATA = 4'h0;	// write only, one character per access.
	localparam logic [3:0] ADDR_STATUS = 4'h4;	// read only.

	localparam int STATUS_BUSY_BIT = 0;
	localparam int STATUS_COL_LSB = 8;	// cursor column, 8 bits wide.
	localparam int STATUS_ROW_LSB = 16;	// cursor row, 8 bits wide.

	// screen row to cell index, the rows form a ring offset by the scroll row.
	function automatic int unsigned cell_index(
		input int unsigned row,
		input int unsigned col,
		input int unsigned scroll,
		input int unsigned rows,
		input int unsigned cols
	);
		int unsigned phys;
		phys = row + scroll;
		if (phys >= rows)
			phys = phys - rows;	// both terms are below rows, one wrap is enough.
		return phys * cols + col;
	endfunction

endpackage

// ==== hw/raster_timing.sv ====
`timescale 1ns/10ps

module raster_timing #(
	parameter int H_ACTIVE = 640,
	parameter int H_FRONT = 16,
	parameter int H_SYNC = 96,
	parameter int H_BACK = 48,
	parameter int V_ACTIVE = 480,
	parameter int V_FRONT = 10,
	parameter int V_SYNC = 2,
	parameter int V_BACK = 33
) (
	input logic pixclk,
	input logic resetcountdown,
	output logic [15:0] px,
	output logic [15:0] py,
	output logic hs_raw,
	output logic vs_raw,
	output logic active
);
	localparam logic [15:0] H_LAST = 16'(H_ACTIVE + H_FRONT + H_SYNC + H_BACK - 1);
	localparam logic [15:0] V_LAST = 16'(V_ACTIVE + V_FRONT + V_SYNC + V_BACK - 1);
	localparam int H_SYNC_START = H_ACTIVE + H_FRONT;
	localparam int V_SYNC_START = V_ACTIVE + V_FRONT;

	always_ff @(posedge pixclk) begin
		if (!resetcountdown) begin
			px <= '0;
			py <= '0;
		end else if (px == H_LAST) begin
			px <= '0;
			py <= (py == V_LAST) ? 16'd0 : py + 16'd1;	// next line, or back to the top.
		end else begin
			px <= px + 16'd1;
		end
	end

	// the flags are decoded from the registered position and line up with it.
	assign hs_raw = (px >= H_SYNC_START) && (px < H_SYNC_START + H_SYNC);
	assign vs_raw = (py >= V_SYNC_START) && (py < V_SYNC_START + V_SYNC);
	assign active = (px < H_ACTIVE) && (py < V_ACTIVE);

endmodule

// ==== hw/terminal_writer.sv ====
`timescale 1ns/10ps

module terminal_writer
	import console_pkg::*;
#(
	parameter int COLS = 80,
	parameter int ROWS = 30
) (
	input logic pixclk,
	input logic resetcountdown,
	input logic tx_valid,
	input char_t tx_char,
	output logic tx_ready,
	video_state_if.writer vid
);
	localparam int CELLS = COLS * ROWS;
	localparam int AW = $clog2(CELLS);
	localparam logic [7:0] LAST_COL = 8'(COLS - 1);
	localparam logic [7:0] LAST_ROW = 8'(ROWS - 1);
	localparam logic [AW-1:0] LAST_CELL = AW'(CELLS - 1);

	typedef enum logic [1:0] {
		ST_IDLE,
		ST_NEWLINE,
		ST_CLEAR
	} state_t;

	state_t state;
	logic [7:0] cur_col;
	logic [7:0] cur_row;
	logic [7:0] scroll;
	logic [AW-1:0] clr_addr;
	logic [AW-1:0] clr_last;
	logic take;
	logic printable;
	logic line_step;
	logic [AW-1:0] cell_addr;
	logic [AW-1:0] top_base;

	assign tx_ready = (state == ST_IDLE);
	assign take = tx_valid && tx_ready;
	assign printable = (tx_char >= CH_SPACE) && (tx_char < 8'h7F);
	assign line_step = (take && tx_char == CH_LF) || (state == ST_NEWLINE);	// LF or wrap.
	assign cell_addr = AW'(cell_index(cur_row, cur_col, scroll, ROWS, COLS));
	assign top_base = AW'(scroll * COLS);	// the old top row becomes the new bottom row.

	assign vid.scroll_row = scroll;
	assign vid.cursor_col = cur_col;
	assign vid.cursor_row = cur_row;

	// one cell write per cycle, either a clear or the accepted character.
	always_comb begin
		vid.wr = 1'b0;
		vid.waddr = cell_addr;
		vid.wdata = tx_char;
		if (state == ST_CLEAR) begin
			vid.wr = 1'b1;
			vid.waddr = clr_addr;
			vid.wdata = CH_SPACE;
		end else if (take && printable) begin
			vid.wr = 1'b1;
		end
	end

	// ==================================================
	// cursor, scroll and clear control
	// ==================================================

	always_ff @(posedge pixclk) begin
		if (!resetcountdown) begin
			state <= ST_CLEAR;	// blank the whole memory first.
			cur_col <= '0;
			cur_row <= '0;
			scroll <= '0;
			clr_addr <= '0;
			clr_last <= LAST_CELL;
		end else begin
			case (state)
				ST_IDLE: begin
					if (take && printable) begin
						if (cur_col == LAST_COL) begin
							cur_col <= '0;
							state <= ST_NEWLINE;
						end else begin
							cur_col <= cur_col + 8'd1;
						end
					end else if (take) begin
						case (tx_char)
							CH_CR, CH_LF: cur_col <= '0;
							CH_BS: begin
								if (cur_col != 8'd0)
									cur_col <= cur_col - 8'd1;
							end
							CH_FF: begin
								clr_addr <= '0;
								clr_last <= LAST_CELL;
								cur_col <= '0;
								cur_row <= '0;
								scroll <= '0;
								state <= ST_CLEAR;
							end
							default: ;	// other control codes are dropped.
						endcase
					end
				end
				ST_CLEAR: begin
					clr_addr <= clr_addr + 1'b1;
					if (clr_addr == clr_last)
						state <= ST_IDLE;
				end
				default: ;
			endcase

			if (line_step) begin
				if (cur_row != LAST_ROW) begin
					cur_row <= cur_row + 8'd1;
					state <= ST_IDLE;
				end else begin
					scroll <= (scroll == LAST_ROW) ? 8'd0 : scroll + 8'd1;
					clr_addr <= top_base;
					clr_last <= top_base + AW'(COLS - 1);
					state <= ST_CLEAR;	// blank the row that just came in at the bottom.
				end
			end
		end
	end

endmodule

// ==== hw/text_console.sv ====
`timescale 1ns/10ps

module text_console
	import console_pkg::*;
#(
	parameter int COLS = 80,
	parameter int ROWS = 30,
	parameter int H_ACTIVE_CELLS = 80,
	parameter int H_FRONT = 16,
	parameter int H_SYNC = 96,
	parameter int H_BACK = 48,
	parameter int V_FRONT = 10,
	parameter int V_SYNC = 2,
	parameter int V_BACK = 33,
	parameter int BLINK_FRAMES = 30
) (
	input logic pixclk,
	input logic resetcountdown,
	input logic psel,
	input logic penable,
	input logic pwrite,
	input logic [3:0] paddr,
	input logic [31:0] pwdata,
	output logic [31:0] prdata,
	output logic pready,
	output logic pslverr,
	output logic hs,
	output logic vs,
	output logic de,
	output logic pixel,
	output char_t glyph_char,
	output logic [2:0] glyph_row,
	input logic [7:0] glyph_bits
);
	logic tx_valid;
	logic tx_ready;
	char_t tx_char;
	logic [15:0] px;
	logic [15:0] py;
	logic hs_raw;
	logic vs_raw;
	logic active;
	logic [$clog2(COLS*ROWS)-1:0] raddr;
	char_t rdata;

	video_state_if #(.COLS(COLS), .ROWS(ROWS)) vid ();

	// ==================================================
	// host side and terminal FSM
	// ==================================================

	apb_console_regs u_regs (
		.pixclk(pixclk),
		.resetcountdown(resetcountdown),
		.psel(psel),
		.penable(penable),
		.pwrite(pwrite),
		.paddr(paddr),
		.pwdata(pwdata),
		.prdata(prdata),
		.pready(pready),
		.pslverr(pslverr),
		.tx_valid(tx_valid),
		.tx_char(tx_char),
		.tx_ready(tx_ready),
		.cursor_col(vid.cursor_col),
		.cursor_row(vid.cursor_row)
	);

	terminal_writer #(.COLS(COLS), .ROWS(ROWS)) u_writer (
		.pixclk(pixclk),
		.resetcountdown(resetcountdown),
		.tx_valid(tx_valid),
		.tx_char(tx_char),
		.tx_ready(tx_ready),
		.vid(vid.writer)
	);

	// ==================================================
	// display side
	// ==================================================

	raster_timing #(
		.H_ACTIVE(H_ACTIVE_CELLS * 8),
		.H_FRONT(H_FRONT),
		.H_SYNC(H_SYNC),
		.H_BACK(H_BACK),
		.V_ACTIVE(ROWS * 8),	// text rows fill the whole active height.
		.V_FRONT(V_FRONT),
		.V_SYNC(V_SYNC),
		.V_BACK(V_BACK)
	) u_timing (
		.pixclk(pixclk),
		.resetcountdown(resetcountdown),
		.px(px),
		.py(py),
		.hs_raw(hs_raw),
		.vs_raw(vs_raw),
		.active(active)
	);

	video_ram #(.COLS(COLS), .ROWS(ROWS)) u_vram (
		.pixclk(pixclk),
		.vid(vid.display),
		.raddr(raddr),
		.rdata(rdata)
	);

	text_renderer #(.COLS(COLS), .ROWS(ROWS), .BLINK_FRAMES(BLINK_FRAMES)) u_render (
		.pixclk(pixclk),
		.resetcountdown(resetcountdown),
		.px(px),
		.py(py),
		.hs_raw(hs_raw),
		.vs_raw(vs_raw),
		.active(active),
		.raddr(raddr),
		.rdata(rdata),
		.vid(vid.display),
		.glyph_char(glyph_char),
		.glyph_row(glyph_row),
		.glyph_bits(glyph_bits),
		.hs(hs),
		.vs(vs),
		.de(de),
		.pixel(pixel)
	);

endmodule

// ==== hw/text_renderer.sv ====
`timescale 1ns/10ps

module text_renderer
	import console_pkg::*;
#(
	parameter int COLS = 80,
	parameter int ROWS = 30,
	parameter int BLINK_FRAMES = 30
) (
	input logic pixclk,
	input logic resetcountdown,
	input logic [15:0] px,
	input logic [15:0] py,
	input logic hs_raw,
	input logic vs_raw,
	input logic active,
	output logic [$clog2(COLS*ROWS)-1:0] raddr,
	input char_t rdata,
	video_state_if.display vid,
	output char_t glyph_char,
	output logic [2:0] glyph_row,
	input logic [7:0] glyph_bits,
	output logic hs,
	output logic vs,
	output logic de,
	output logic pixel
);
	localparam int AW = $clog2(COLS * ROWS);
	localparam logic [15:0] BLINK_LAST = 16'(BLINK_FRAMES - 1);

	logic [15:0] cell_x;
	logic [15:0] cell_y;
	logic in_text;
	logic on_cursor;
	logic glyph_bit;
	logic frame_start;
	logic [15:0] blink_cnt;
	logic cursor_hidden;

	// stage 1 runs alongside the memory read, stage 2 holds the finished pixel.
	logic s1_hs, s1_vs, s1_active, s1_text, s1_cursor;
	logic [2:0] s1_xbit;
	logic [2:0] s1_row;
	logic s2_hs, s2_vs, s2_de, s2_pixel;

	assign cell_x = px >> 3;
	assign cell_y = py >> 3;
	assign in_text = (cell_x < COLS) && (cell_y < ROWS);
	assign on_cursor = (cell_x == {8'd0, vid.cursor_col}) && (cell_y == {8'd0, vid.cursor_row});
	assign raddr = in_text ? AW'(cell_index(cell_y, cell_x, vid.scroll_row, ROWS, COLS)) : '0;

	assign glyph_char = rdata;
	assign glyph_row = s1_row;
	assign glyph_bit = glyph_bits[3'd7 - s1_xbit];	// bit 7 is the leftmost pixel.
	assign frame_start = vs_raw && !s1_vs;

	always_ff @(posedge pixclk) begin
		s1_xbit <= px[2:0];
		s1_row <= py[2:0];
	end

	always_ff @(posedge pixclk) begin
		if (!resetcountdown) begin
			s1_hs <= 1'b0;
			s1_vs <= 1'b0;
			s1_active <= 1'b0;
			s1_text <= 1'b0;
			s1_cursor <= 1'b0;
			s2_hs <= 1'b0;
			s2_vs <= 1'b0;
			s2_de <= 1'b0;
			s2_pixel <= 1'b0;
			hs <= 1'b0;
			vs <= 1'b0;
			de <= 1'b0;
			pixel <= 1'b0;
		end else begin
			s1_hs <= hs_raw;
			s1_vs <= vs_raw;
			s1_active <= active;
			s1_text <= in_text;
			s1_cursor <= on_cursor;
			s2_hs <= s1_hs;
			s2_vs <= s1_vs;
			s2_de <= s1_active;
			s2_pixel <= s1_active && s1_text && (glyph_bit ^ (s1_cursor && !cursor_hidden));
			hs <= s2_hs;
			vs <= s2_vs;
			de <= s2_de;
			pixel <= s2_pixel;
		end
	end

	// ==================================================
	// cursor blink
	// ==================================================

	always_ff @(posedge pixclk) begin
		if (!resetcountdown) begin
			blink_cnt <= '0;
			cursor_hidden <= 1'b0;	// frame 0 shows the cursor.
		end else if (frame_start) begin
			if (blink_cnt == BLINK_LAST) begin
				blink_cnt <= '0;
				cursor_hidden <= ~cursor_hidden;
			end else begin
				blink_cnt <= blink_cnt + 16'd1;
			end
		end
	end

endmodule

// ==== hw/video_ram.sv ====
`timescale 1ns/10ps

module video_ram
	import console_pkg::*;
#(
	parameter int COLS = 80,
	parameter int ROWS = 30
) (
	input logic pixclk,
	video_state_if.display vid,
	input logic [$clog2(COLS*ROWS)-1:0] raddr,
	output char_t rdata
);
	char_t cells [COLS*ROWS];	// one character code per screen cell.

	always_ff @(posedge pixclk) begin
		if (vid.wr)
			cells[vid.waddr] <= vid.wdata;
	end

	always_ff @(posedge pixclk) begin
		rdata <= cells[raddr];	// data follows the address by one cycle.
	end

endmodule

// ==== hw/video_state_if.sv ====
`timescale 1ns/10ps

interface video_state_if
	import console_pkg::*;
#(
	parameter int COLS = 80,
	parameter int ROWS = 30
) ();
	logic wr;
	logic [$clog2(COLS*ROWS)-1:0] waddr;
	char_t wdata;
	logic [7:0] scroll_row;	// physical row that shows as screen row 0.
	logic [7:0] cursor_col;
	logic [7:0] cursor_row;

	modport writer (
		output wr, waddr, wdata,
		output scroll_row, cursor_col, cursor_row
	);

	modport display (
		input wr, waddr, wdata,
		input scroll_row, cursor_col, cursor_row
	);

endinterface

// ==== text_console.f ====
hw/console_pkg.sv
hw/video_state_if.sv
hw/apb_console_regs.sv
hw/terminal_writer.sv
hw/raster_timing.sv
hw/video_ram.sv
hw/text_renderer.sv
hw/text_console.sv
bench/tb_text_console.sv
